// ==== bench/adc_link_stimulus.txt ====
# name cmd adc_value(hex or R) bad_parity reply_count byte0 byte1
# R draws the value from the LCG and the reply bytes are worked out from it
read_early   9B 123 0 0 00 00
ack_bad_par  33 000 1 0 00 00
link_open    33 000 0 1 33 00
read_zero    9B 000 0 2 00 00
read_full    9B FFF 0 2 0F FF
read_a5c     9B A5C 0 2 0A 5C
read_bad_par 9B 3C3 1 0 00 00
unknown_byte 5A 000 0 0 00 00
ack_again    33 000 0 1 33 00
read_rand0   9B R   0 2 00 00
read_rand1   9B R   0 2 00 00
read_rand2   9B R   0 2 00 00
read_rand3   9B R   0 2 00 00
read_rand4   9B R   0 2 00 00

// ==== bench/adc_link_tb.sv ====
`timescale 1ns/1ps

module adc_link_tb;
    import uart_pkg::*;
    import sampler_pkg::*;

    localparam int RESET_CYCLES = 10;

    // Longer than a full conversion followed by two reply frames
    localparam int QUIET_CYCLES =
        2 * (2 * FRAME_BITS * CLKS_PER_BIT + ADC_FRAME_BITS * SCLK_DIV);

    // One line of the stimulus file after the random values are resolved
    typedef struct packed {
        logic [127:0]         name;
        logic [7:0]           cmd;
        logic [ADC_WIDTH-1:0] value;
        logic                 bad_parity;
        logic [1:0]           count;
        logic [7:0]           byte0;
        logic [7:0]           byte1;
    } test_t;

    logic clk;
    logic rst;
    logic rx;
    logic adc_sdo = 1'b0;
    logic tx;
    logic adc_cs;
    logic adc_sclk;
    logic link_up;

    test_t                tests[$];
    bit                   tests_loaded = 1'b0;
    bit                   link_model = 1'b0;
    logic [31:0]          lcg_state = 32'h389f_9a2c;
    logic [ADC_WIDTH-1:0] adc_value = '0;

    logic        prev_cs;
    logic        prev_sclk;
    logic [15:0] slave_shift;

    adc_link_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .adc_sdo  (adc_sdo),
        .tx       (tx),
        .adc_cs   (adc_cs),
        .adc_sclk (adc_sclk),
        .link_up  (link_up)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input logic [127:0] test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("ERR %0s %0s expected 0x%0h actual 0x%0h",
                                test_name, what, expected, actual));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Hex digits of a short text field, right-justified in the vector
    function automatic logic [ADC_WIDTH-1:0] hex_text_value(input logic [31:0] txt);
        logic [ADC_WIDTH-1:0] v;
        logic [7:0]           c;
        v = '0;
        for (int i = 3; i >= 0; i--) begin
            c = txt[i*8 +: 8];
            if (c >= "0" && c <= "9") begin
                v = {v[ADC_WIDTH-5:0], 4'(c - "0")};
            end else if (c >= "A" && c <= "F") begin
                v = {v[ADC_WIDTH-5:0], 4'(c - "A" + 8'd10)};
            end else if (c >= "a" && c <= "f") begin
                v = {v[ADC_WIDTH-5:0], 4'(c - "a" + 8'd10)};
            end
        end
        return v;
    endfunction

    task automatic load_tests();
        int           fd;
        int           items;
        int           bad_i;
        int           count_i;
        string        line;
        logic [127:0] name;
        logic [7:0]   cmd;
        logic [31:0]  val_txt;
        logic [7:0]   b0;
        logic [7:0]   b1;
        test_t        t;
        fd = $fopen("bench/adc_link_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open bench/adc_link_stimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            items = $fgets(line, fd);
            if (items == 0 || line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            items = $sscanf(line, "%s %h %s %d %d %h %h",
                            name, cmd, val_txt, bad_i, count_i, b0, b1);
            if (items <= 0) begin
                continue;
            end
            if (items != 7) begin
                abort_run($sformatf("Malformed stimulus line: %s", line));
            end
            t.name       = name;
            t.cmd        = cmd;
            t.bad_parity = (bad_i != 0);
            if (val_txt == {24'h0, "R"}) begin
                // Random reads always answer with the high and low halves of the value
                lcg_state = lcg_next(lcg_state);
                t.value   = lcg_state[27:16];
                t.count   = 2'd2;
                t.byte0   = {4'h0, t.value[11:8]};
                t.byte1   = t.value[7:0];
            end else begin
                t.value = hex_text_value(val_txt);
                t.count = 2'(count_i);
                t.byte0 = b0;
                t.byte1 = b1;
            end
            tests.push_back(t);
        end
        $fclose(fd);
    endtask

    // Start bit, data LSB first, even parity (optionally inverted) and stop bit
    task automatic send_byte(input logic [7:0] data, input logic bad);
        logic [10:0] frame;
        frame = {1'b1, (^data) ^ bad, data, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic receive_byte(output logic [7:0] data);
        logic [10:0] frame;
        @(posedge clk);
        while (tx !== 1'b0) begin
            @(posedge clk);
        end
        repeat (CLKS_PER_BIT / 2) @(posedge clk);
        frame[0] = tx;
        for (int i = 1; i < FRAME_BITS; i++) begin
            repeat (CLKS_PER_BIT) @(posedge clk);
            frame[i] = tx;
        end
        if (frame[0] !== 1'b0) begin
            abort_run("Start bit on tx did not stay low until mid-bit");
        end
        if ((^frame[9:1]) !== 1'b0) begin
            abort_run("Reply frame on tx has a wrong even parity bit");
        end
        if (frame[10] !== 1'b1) begin
            abort_run("Reply frame on tx has a low stop bit");
        end
        data = frame[8:1];
    endtask

    // Nothing may leave the device and no conversion may start
    task automatic expect_quiet();
        repeat (QUIET_CYCLES) begin
            @(posedge clk);
            if (tx !== 1'b1) begin
                abort_run("A frame appeared on tx where no reply was expected");
            end
            if (adc_cs !== 1'b1) begin
                abort_run("adc_cs went low where no conversion was expected");
            end
        end
    endtask

    task automatic run_test(input test_t t);
        logic [7:0] got;
        adc_value = t.value;
        send_byte(t.cmd, t.bad_parity);
        if (t.cmd == CMD_ACK && !t.bad_parity) begin
            link_model = 1'b1;
        end
        if (t.count == 2'd0) begin
            expect_quiet();
        end else begin
            receive_byte(got);
            check_value(t.name, "reply byte 0", 32'(t.byte0), 32'(got));
            if (t.count == 2'd2) begin
                receive_byte(got);
                check_value(t.name, "reply byte 1", 32'(t.byte1), 32'(got));
            end
        end
        check_value(t.name, "link_up", 32'(link_model), 32'(link_up));
    endtask

    // ADC slave, four zeros then the 12-bit value, MSB first on falling sclk
    always @(posedge clk) begin
        if (rst) begin
            prev_cs   <= 1'b1;
            prev_sclk <= 1'b1;
        end else begin
            prev_cs   <= adc_cs;
            prev_sclk <= adc_sclk;
            if (prev_cs && adc_cs && (adc_sclk !== prev_sclk)) begin
                abort_run("adc_sclk toggled while adc_cs was high");
            end
            if (prev_cs && !adc_cs) begin
                slave_shift <= {4'h0, adc_value};
            end else if (!adc_cs && prev_sclk && !adc_sclk) begin
                adc_sdo     <= slave_shift[15];
                slave_shift <= {slave_shift[14:0], 1'b0};
            end
        end
    end

    initial begin
        int limit;
        wait (tests_loaded);
        limit = RESET_CYCLES + tests.size() * 2 *
                (3 * FRAME_BITS * CLKS_PER_BIT + ADC_FRAME_BITS * SCLK_DIV + QUIET_CYCLES);
        repeat (limit) @(posedge clk);
        abort_run("Watchdog expired before all tests finished");
    end

    initial begin
        rx  <= 1'b1;
        rst <= 1'b1;
        load_tests();
        tests_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value({40'h0, "reset_state"}, "tx", 32'd1, 32'(tx));
        check_value({40'h0, "reset_state"}, "adc_cs", 32'd1, 32'(adc_cs));
        check_value({40'h0, "reset_state"}, "adc_sclk", 32'd1, 32'(adc_sclk));
        check_value({40'h0, "reset_state"}, "link_up", 32'd0, 32'(link_up));
        foreach (tests[i]) begin
            run_test(tests[i]);
        end
        $display("Test passed");
        $finish;
    end

endmodule

// ==== hdl/adc_link_top.sv ====
`timescale 1ns/1ps

module adc_link_top (
    input  logic clk,
    input  logic rst,
    input  logic rx,
    input  logic adc_sdo,
    output logic tx,
    output logic adc_cs,
    output logic adc_sclk,
    output logic link_up
);
    import uart_pkg::*;
    import sampler_pkg::*;

    rx_byte_t   rx_byte;
    cmd_t       cmd;
    reply_t     reply;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    uart_rx receiver (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .rx_byte (rx_byte)
    );

    command_decoder decoder (
        .clk     (clk),
        .rst     (rst),
        .rx_byte (rx_byte),
        .cmd     (cmd),
        .link_up (link_up)
    );

    adc_spi_reader adc_reader (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .adc_sdo  (adc_sdo),
        .adc_cs   (adc_cs),
        .adc_sclk (adc_sclk),
        .reply    (reply)
    );

    reply_serializer serializer (
        .clk      (clk),
        .rst      (rst),
        .reply    (reply),
        .tx_busy  (tx_busy),
        .tx_data  (tx_data),
        .tx_start (tx_start)
    );

    // tx_busy is the only signal running back up the chain
    uart_tx transmitter (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

// ==== hdl/adc_spi_reader.sv ====
`timescale 1ns/1ps

module adc_spi_reader (
    input  logic                clk,
    input  logic                rst,
    input  sampler_pkg::cmd_t   cmd,
    input  logic                adc_sdo,
    output logic                adc_cs,
    output logic                adc_sclk,
    output sampler_pkg::reply_t reply
);
    import sampler_pkg::*;

    typedef enum logic {
        SPI_IDLE,
        SPI_CONV
    } spi_state_t;

    spi_state_t             state;
    logic [SCLK_CNT_W-1:0]  div_cnt;
    logic [FRAME_CNT_W-1:0] bit_cnt;
    logic [ADC_WIDTH-1:0]   shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= SPI_IDLE;
            adc_cs      <= 1'b1;
            adc_sclk    <= 1'b1;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            reply.valid <= 1'b0;
        end else begin
            reply.valid <= 1'b0;
            case (state)
                SPI_IDLE: begin
                    if (cmd.valid && cmd.op == OP_ACK) begin
                        reply.valid <= 1'b1;
                        reply.op    <= OP_ACK;
                        reply.value <= '0;
                    end else if (cmd.valid && cmd.op == OP_READ) begin
                        state   <= SPI_CONV;
                        adc_cs  <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
                SPI_CONV: begin
                    // Commands arriving mid-conversion are dropped
                    div_cnt <= div_cnt + 1'b1;
                    if (div_cnt == '0) begin
                        adc_sclk <= 1'b0;
                    end
                    if (div_cnt == SCLK_CNT_W'(SCLK_DIV / 2)) begin
                        adc_sclk <= 1'b1;
                        // The four leading zeros shift out of the top on their own
                        shift    <= {shift[ADC_WIDTH-2:0], adc_sdo};
                    end
                    if (div_cnt == SCLK_CNT_W'(SCLK_DIV - 1)) begin
                        div_cnt <= '0;
                        if (bit_cnt == FRAME_CNT_W'(ADC_FRAME_BITS - 1)) begin
                            state       <= SPI_IDLE;
                            adc_cs      <= 1'b1;
                            reply.valid <= 1'b1;
                            reply.op    <= OP_READ;
                            reply.value <= shift;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= SPI_IDLE;
                end
            endcase
        end
    end

    // The serial clock only moves inside a chip-select window
    assert property (@(posedge clk) disable iff (rst) adc_cs |-> adc_sclk);

    // Read replies leave together with the release of chip select
    assert property (@(posedge clk) disable iff (rst)
        (reply.valid && reply.op == OP_READ) |-> $rose(adc_cs));

endmodule

// ==== hdl/command_decoder.sv ====
`timescale 1ns/1ps

module command_decoder (
    input  logic               clk,
    input  logic               rst,
    input  uart_pkg::rx_byte_t rx_byte,
    output sampler_pkg::cmd_t  cmd,
    output logic               link_up
);
    import sampler_pkg::*;

    logic byte_ok;
    logic is_ack;
    logic is_read;

    // Bytes that failed the parity check are treated as if never received
    assign byte_ok = rx_byte.valid && !rx_byte.parity_error;
    assign is_ack  = byte_ok && (rx_byte.data == CMD_ACK);

    // A read request counts only once the host has opened the link
    assign is_read = byte_ok && (rx_byte.data == CMD_READ_ADC) && link_up;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd.valid <= 1'b0;
            link_up   <= 1'b0;
        end else begin
            cmd.valid <= 1'b0;
            if (is_ack) begin
                cmd.valid <= 1'b1;
                cmd.op    <= OP_ACK;
                // The link stays up until the next reset
                link_up   <= 1'b1;
            end else if (is_read) begin
                cmd.valid <= 1'b1;
                cmd.op    <= OP_READ;
            end
        end
    end

endmodule

// ==== hdl/reply_serializer.sv ====
`timescale 1ns/1ps

module reply_serializer (
    input  logic                clk,
    input  logic                rst,
    input  sampler_pkg::reply_t reply,
    input  logic                tx_busy,
    output logic [7:0]          tx_data,
    output logic                tx_start
);
    import sampler_pkg::*;

    logic [1:0] pending;
    logic [7:0] next_byte;
    logic [7:0] last_byte;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending  <= 2'd0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (pending == 2'd0) begin
                if (reply.valid && reply.op == OP_ACK) begin
                    next_byte <= CMD_ACK;
                    pending   <= 2'd1;
                end else if (reply.valid) begin
                    // High byte pads the upper value bits with zeros
                    next_byte <= {{(16 - ADC_WIDTH){1'b0}}, reply.value[ADC_WIDTH-1:8]};
                    last_byte <= reply.value[7:0];
                    pending   <= 2'd2;
                end
            end else if (!tx_busy && !tx_start) begin
                // tx_busy rises one cycle after tx_start, so hold off for that cycle
                tx_start  <= 1'b1;
                tx_data   <= next_byte;
                next_byte <= last_byte;
                pending   <= pending - 1'b1;
            end
        end
    end

    // Only an idle transmitter is ever started
    assert property (@(posedge clk) disable iff (rst) !(tx_start && tx_busy));

endmodule

// ==== hdl/sampler_pkg.sv ====
package sampler_pkg;

    // Bytes the host sends to the sampler
    localparam logic [7:0] CMD_ACK      = 8'h33;
    localparam logic [7:0] CMD_READ_ADC = 8'h9B;

    // SPI timing of one conversion on the ADC
    localparam int SCLK_DIV       = 4;
    localparam int ADC_FRAME_BITS = 16;
    localparam int ADC_WIDTH      = 12;

    // Counter widths for the SPI clock divider and the bit counter
    localparam int SCLK_CNT_W  = $clog2(SCLK_DIV);
    localparam int FRAME_CNT_W = $clog2(ADC_FRAME_BITS);

    typedef enum logic {
        OP_ACK  = 1'b0,
        OP_READ = 1'b1
    } cmd_op_t;

    // Decoded command strobe from the decoder to the SPI reader
    typedef struct packed {
        logic    valid;
        cmd_op_t op;
    } cmd_t;

    // Reply strobe to the serializer, value is zero for an acknowledgement
    typedef struct packed {
        logic                 valid;
        cmd_op_t              op;
        logic [ADC_WIDTH-1:0] value;
    } reply_t;

endpackage

// ==== hdl/uart_pkg.sv ====
package uart_pkg;

    // Clocks spent on each bit of a UART frame
    localparam int CLKS_PER_BIT = 4;

    // Width of the per-bit clock counter in both UART directions
    localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);

    // Start bit, eight data bits, even parity and stop bit
    localparam int FRAME_BITS = 11;

    // One received byte as it leaves the receiver
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       parity_error;
    } rx_byte_t;

endpackage

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx,
    output uart_pkg::rx_byte_t rx_byte
);
    import uart_pkg::*;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    rx_state_t            state;
    logic [1:0]           rx_sync;
    logic [BIT_CNT_W-1:0] clk_cnt;
    logic [2:0]           bit_idx;
    logic [7:0]           shift;
    logic                 parity_bit;
    logic                 bit_end;

    // Two flops bring the pin into the clock domain, rx_sync[1] is the clean copy
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    // Starting from the mid-point of the start bit, every full count is mid-bit again
    assign bit_end = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= RX_IDLE;
            clk_cnt       <= '0;
            bit_idx       <= '0;
            rx_byte.valid <= 1'b0;
        end else begin
            rx_byte.valid <= 1'b0;
            clk_cnt       <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    // Falling edge seen as the low level enters the second flop
                    if (rx_sync[1] && !rx_sync[0]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // A glitch that is high again by mid-bit is not a start bit
                        state   <= rx_sync[1] ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        shift   <= {rx_sync[1], shift[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_PARITY;
                        end
                    end
                end
                RX_PARITY: begin
                    if (bit_end) begin
                        clk_cnt    <= '0;
                        parity_bit <= rx_sync[1];
                        state      <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        state <= RX_IDLE;
                        // Frames with a low stop bit never leave the receiver
                        if (rx_sync[1]) begin
                            rx_byte.valid        <= 1'b1;
                            rx_byte.data         <= shift;
                            rx_byte.parity_error <= (^shift) != parity_bit;
                        end
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Downstream stages treat valid as a single-cycle event
    assert property (@(posedge clk) disable iff (rst) rx_byte.valid |=> !rx_byte.valid);

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx,
    output logic       tx_busy
);
    import uart_pkg::*;

    logic [FRAME_BITS-1:0] frame;
    logic [BIT_CNT_W-1:0]  clk_cnt;
    logic [3:0]            bit_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                // Bits leave from the bottom, start bit first and stop bit last
                frame   <= {1'b1, ^tx_data, tx_data, 1'b0};
                tx      <= 1'b0;
                tx_busy <= 1'b1;
                clk_cnt <= '0;
                bit_idx <= '0;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
                clk_cnt <= '0;
                if (bit_idx == 4'(FRAME_BITS - 1)) begin
                    // Stop bit done, the line simply stays high
                    tx_busy <= 1'b0;
                    tx      <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                    frame   <= {1'b1, frame[FRAME_BITS-1:1]};
                    tx      <= frame[1];
                end
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module adc_link_tb -f src.f -o adc_link_sim

# The simulator exits with an error status on $fatal, so the log decides
./obj_dir/adc_link_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi

if ! grep -q "Test passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

// ==== src.f ====
hdl/uart_pkg.sv
hdl/sampler_pkg.sv
hdl/uart_rx.sv
hdl/command_decoder.sv
hdl/adc_spi_reader.sv
hdl/reply_serializer.sv
hdl/uart_tx.sv
hdl/adc_link_top.sv
bench/adc_link_tb.sv
